//--- Bender.yml
package:
  name: vmul

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/vmul_pkg.sv
      - verilog/vmul_ctrl.sv
      - verilog/vmul_operand_prep.sv
      - verilog/vmul_product_array.sv
      - verilog/vmul_result_fmt.sv
      - verilog/vmul_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - tb/vmul_properties.sv
      - tb/vmul_tb.sv

//--- flist.f
+incdir+verilog
verilog/vmul_pkg.sv
verilog/vmul_ctrl.sv
verilog/vmul_operand_prep.sv
verilog/vmul_product_array.sv
verilog/vmul_result_fmt.sv
verilog/vmul_top.sv
tb/vmul_properties.sv
tb/vmul_tb.sv

//--- tb/vmul_properties.sv
`timescale 1ns/1ps
`include "vmul_settings.svh"

module vmul_properties (
    input logic                  clk_i,
    input logic                  rstn_i,
    input logic                  valid_i,
    input logic                  valid_o,
    input logic [`VMUL_XLEN-1:0] data_vd_o
);

    // no result leaves the pipeline during reset
    valid_low_in_reset: assert property (@(posedge clk_i) !rstn_i |-> !valid_o)
        else $error("valid_o high while reset is asserted");

    // fixed latency, one output strobe per input strobe
    valid_latency: assert property (@(posedge clk_i) disable iff (!rstn_i)
        valid_o == $past(valid_i, `VMUL_LATENCY))
        else $error("valid_o does not follow valid_i by the pipeline latency");

    result_known: assert property (@(posedge clk_i) disable iff (!rstn_i)
        valid_o |-> !$isunknown(data_vd_o))
        else $error("data_vd_o has unknown bits while valid_o is high");

endmodule

bind vmul_top vmul_properties u_properties (
    .clk_i     (clk_i),
    .rstn_i    (rstn_i),
    .valid_i   (valid_i),
    .valid_o   (valid_o),
    .data_vd_o (data_vd_o)
);

//--- tb/vmul_tb.sv
`timescale 1ns/1ps
`include "vmul_settings.svh"

module vmul_tb;

    localparam int RANDOM_OPS     = 30;
    // reset, directed ops, random ops and one flush per test
    localparam int TEST_CYCLES    = 4 + 1 + 8 + 12 + 12 + 16 + RANDOM_OPS + 5 * `VMUL_LATENCY;
    localparam int TIMEOUT_CYCLES = TEST_CYCLES + 60;

    logic                  clk_i;
    logic                  rstn_i;
    logic                  valid_i;
    vmul_pkg::instr_type_t instr_type_i;
    vmul_pkg::sew_t        sew_i;
    logic [`VMUL_XLEN-1:0] data_vs1_i;
    logic [`VMUL_XLEN-1:0] data_vs2_i;
    logic [`VMUL_XLEN-1:0] data_vd_i;
    logic                  valid_o;
    logic [`VMUL_XLEN-1:0] data_vd_o;

    integer           seed;
    int               cycle_cnt;
    int               pulses;
    // expected results in flight, index 0 is the newest
    logic             exp_valid [`VMUL_LATENCY];
    vmul_pkg::vword_u exp_word  [`VMUL_LATENCY];
    // last result seen, held between strobes
    vmul_pkg::vword_u held_word;

    vmul_top DUT (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .valid_i      (valid_i),
        .instr_type_i (instr_type_i),
        .sew_i        (sew_i),
        .data_vs1_i   (data_vs1_i),
        .data_vs2_i   (data_vs2_i),
        .data_vd_i    (data_vd_i),
        .valid_o      (valid_o),
        .data_vd_o    (data_vd_o)
    );

    always #50 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_cnt++;
        if (cycle_cnt > TIMEOUT_CYCLES) begin
            fail_run("timeout, the tests ran longer than the cycle limit");
        end
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Simulation FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_word(input string name, input vmul_pkg::vword_u got,
                              input vmul_pkg::vword_u exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
            fail_run("result word differs from the model");
        end
    endtask

    task automatic check_valid(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
            fail_run("output strobe differs from the expected timing");
        end
    endtask

    ////////////////////
    // reference model
    ////////////////////

    function automatic logic [63:0] elem_of(input vmul_pkg::vword_u w,
                                            input vmul_pkg::sew_t sew, input int k);
        case (sew)
            vmul_pkg::SEW_8:  return 64'(w.e8[k]);
            vmul_pkg::SEW_16: return 64'(w.e16[k]);
            vmul_pkg::SEW_32: return 64'(w.e32[k]);
            default:          return w.e64;
        endcase
    endfunction

    function automatic vmul_pkg::vword_u set_elem(input vmul_pkg::vword_u w, input int ew,
                                                  input int k, input logic [63:0] v);
        case (ew)
            8:       w.e8[k] = v[7:0];
            16:      w.e16[k] = v[15:0];
            32:      w.e32[k] = v[31:0];
            default: w.e64 = v;
        endcase
        return w;
    endfunction

    function automatic logic [127:0] sign_ext(input logic [63:0] v, input int ew,
                                              input logic sgn);
        logic [127:0] x;
        x = {64'b0, v};
        if (sgn && v[ew-1]) begin
            x = x | ({128{1'b1}} << ew);
        end
        return x;
    endfunction

    function automatic vmul_pkg::vword_u model_result(input vmul_pkg::instr_type_t instr,
                                                      input vmul_pkg::sew_t sew,
                                                      input logic [63:0] vs1,
                                                      input logic [63:0] vs2,
                                                      input logic [63:0] vd);
        int               ew;
        int               n;
        logic             both_u;
        logic             mixed;
        logic             widen;
        logic             mulh;
        logic             acc;
        logic             sub;
        logic             swap;
        vmul_pkg::vword_u a;
        vmul_pkg::vword_u b;
        vmul_pkg::vword_u c;
        vmul_pkg::vword_u res;
        logic [127:0]     p;
        logic [127:0]     r;
        ew     = 8 << int'(sew);
        n      = 64 / ew;
        both_u = (instr == vmul_pkg::VMULHU) || (instr == vmul_pkg::VWMULU);
        mixed  = (instr == vmul_pkg::VMULHSU) || (instr == vmul_pkg::VWMULSU);
        widen  = (instr == vmul_pkg::VWMUL) || (instr == vmul_pkg::VWMULU) ||
                 (instr == vmul_pkg::VWMULSU);
        mulh   = (instr == vmul_pkg::VMULH) || (instr == vmul_pkg::VMULHU) ||
                 (instr == vmul_pkg::VMULHSU);
        sub    = (instr == vmul_pkg::VNMSAC) || (instr == vmul_pkg::VNMSUB);
        swap   = (instr == vmul_pkg::VMADD) || (instr == vmul_pkg::VNMSUB);
        acc    = (instr == vmul_pkg::VMACC) || (instr == vmul_pkg::VMADD) || sub;
        a      = vs1;
        b      = swap ? vd : vs2;
        c      = swap ? vs2 : vd;
        res    = '0;
        // no 128-bit destination for widening
        if (widen && sew == vmul_pkg::SEW_64) begin
            return res;
        end
        if (widen) begin
            n = n / 2;
        end
        for (int k = 0; k < n; k++) begin
            p = sign_ext(elem_of(a, sew, k), ew, !both_u && !mixed) *
                sign_ext(elem_of(b, sew, k), ew, !both_u);
            if (acc) begin
                r = sub ? {64'b0, elem_of(c, sew, k)} - p : {64'b0, elem_of(c, sew, k)} + p;
            end else if (mulh) begin
                r = p >> ew;
            end else begin
                r = p;
            end
            res = set_elem(res, widen ? 2 * ew : ew, k, r[63:0]);
        end
        return res;
    endfunction

    ////////////////////
    // stimulus
    ////////////////////

    // one clock: check what leaves the pipeline, then drive the next slot
    task automatic drive_cycle(input logic v, input vmul_pkg::instr_type_t instr,
                               input vmul_pkg::sew_t sew, input logic [63:0] vs1,
                               input logic [63:0] vs2, input logic [63:0] vd);
        @(negedge clk_i);
        if (valid_o === 1'b1) begin
            pulses++;
        end
        check_valid("valid_o", valid_o, exp_valid[`VMUL_LATENCY-1]);
        if (exp_valid[`VMUL_LATENCY-1]) begin
            check_word("data_vd_o", data_vd_o, exp_word[`VMUL_LATENCY-1]);
            held_word = exp_word[`VMUL_LATENCY-1];
        end else begin
            check_word("data_vd_o", data_vd_o, held_word);
        end
        valid_i      = v;
        instr_type_i = instr;
        sew_i        = sew;
        data_vs1_i   = vs1;
        data_vs2_i   = vs2;
        data_vd_i    = vd;
        for (int i = `VMUL_LATENCY - 1; i > 0; i--) begin
            exp_valid[i] = exp_valid[i-1];
            exp_word[i]  = exp_word[i-1];
        end
        exp_valid[0] = v;
        exp_word[0]  = v ? model_result(instr, sew, vs1, vs2, vd) : '0;
    endtask

    task automatic flush_pipe();
        repeat (`VMUL_LATENCY) begin
            drive_cycle(1'b0, vmul_pkg::VMUL, vmul_pkg::SEW_8, '0, '0, '0);
        end
    endtask

    task automatic test_reset();
        @(negedge clk_i);
        check_valid("valid_o", valid_o, 1'b0);
        check_word("data_vd_o", data_vd_o, '0);
    endtask

    task automatic test_vmul();
        logic [63:0] most_neg [4];
        most_neg = '{64'h8080_8080_8080_8080, 64'h8000_8000_8000_8000,
                     64'h8000_0000_8000_0000, 64'h8000_0000_0000_0000};
        for (int s = 0; s < 4; s++) begin
            // most negative times -1 wraps back to itself
            drive_cycle(1'b1, vmul_pkg::VMUL, vmul_pkg::sew_t'(s), most_neg[s], '1, '0);
            drive_cycle(1'b1, vmul_pkg::VMUL, vmul_pkg::sew_t'(s), 64'h7fff_8001_ff80_017f,
                        64'h8000_7fff_ff01_7f80, '0);
        end
        flush_pipe();
    endtask

    task automatic test_mulh();
        vmul_pkg::instr_type_t ops [3];
        ops = '{vmul_pkg::VMULH, vmul_pkg::VMULHU, vmul_pkg::VMULHSU};
        foreach (ops[i]) begin
            for (int s = 0; s < 4; s++) begin
                drive_cycle(1'b1, ops[i], vmul_pkg::sew_t'(s), 64'hfedc_ba98_8000_7fff,
                            64'h8001_ff7f_0123_fffe, '0);
            end
        end
        flush_pipe();
    endtask

    task automatic test_widen();
        vmul_pkg::instr_type_t ops [3];
        ops = '{vmul_pkg::VWMUL, vmul_pkg::VWMULU, vmul_pkg::VWMULSU};
        foreach (ops[i]) begin
            for (int s = 0; s < 4; s++) begin
                drive_cycle(1'b1, ops[i], vmul_pkg::sew_t'(s), 64'hdead_beef_8765_fa81,
                            64'h0bad_f00d_7f80_c3ff, 64'hffff_ffff_ffff_ffff);
            end
        end
        flush_pipe();
    endtask

    task automatic test_macc();
        vmul_pkg::instr_type_t ops [4];
        ops = '{vmul_pkg::VMACC, vmul_pkg::VNMSAC, vmul_pkg::VMADD, vmul_pkg::VNMSUB};
        foreach (ops[i]) begin
            for (int s = 0; s < 4; s++) begin
                drive_cycle(1'b1, ops[i], vmul_pkg::sew_t'(s), 64'h9abc_0f1e_8001_fe03,
                            64'h1357_9bdf_0246_8ace, 64'hf00d_cafe_7f80_0155);
            end
        end
        flush_pipe();
    endtask

    task automatic test_random();
        int unsigned r;
        int          start;
        start = pulses;
        repeat (RANDOM_OPS) begin
            r = $random(seed);
            drive_cycle(1'b1, vmul_pkg::instr_type_t'(r % 11), vmul_pkg::sew_t'(r[9:8]),
                        {$random(seed), $random(seed)}, {$random(seed), $random(seed)},
                        {$random(seed), $random(seed)});
        end
        flush_pipe();
        if (pulses - start != RANDOM_OPS) begin
            fail_run("random test saw the wrong number of result strobes");
        end
    endtask

    initial begin
        seed         = 32'h5269;
        cycle_cnt    = 0;
        pulses       = 0;
        held_word    = '0;
        clk_i        = 1'b0;
        rstn_i       = 1'b0;
        valid_i      = 1'b0;
        instr_type_i = vmul_pkg::VMUL;
        sew_i        = vmul_pkg::SEW_8;
        data_vs1_i   = '0;
        data_vs2_i   = '0;
        data_vd_i    = '0;
        for (int i = 0; i < `VMUL_LATENCY; i++) begin
            exp_valid[i] = 1'b0;
            exp_word[i]  = '0;
        end
        repeat (4) @(negedge clk_i);
        rstn_i = 1'b1;
        test_reset();
        test_vmul();
        test_mulh();
        test_widen();
        test_macc();
        test_random();
        $display("Simulation PASSED");
        $finish;
    end

endmodule

//--- verilog/vmul_ctrl.sv
`timescale 1ns/1ps
`include "vmul_settings.svh"

module vmul_ctrl (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  logic                  valid_i,
    input  vmul_pkg::instr_type_t instr_type_i,
    input  vmul_pkg::sew_t        sew_i,
    output logic                  src1_signed_o,
    output logic                  src2_signed_o,
    output logic                  swap_addend_o,
    output vmul_pkg::sew_t        sew_s1_o,
    output vmul_pkg::sew_t        sew_s2_o,
    output logic                  is_mulh_o,
    output logic                  is_widened_o,
    output logic                  is_acc_o,
    output logic                  is_sub_o,
    output logic                  valid_s2_o,
    output logic                  valid_o
);

    logic                     is_signed;
    logic                     is_mixed;
    logic [3:0]               flags_d;
    logic [3:0]               flags_s1;
    logic [3:0]               flags_s2;
    logic [`VMUL_LATENCY-1:0] valid_q;

    ////////////////////
    // decode
    ////////////////////

    always_comb begin
        is_signed = (instr_type_i != vmul_pkg::VMULHU) && (instr_type_i != vmul_pkg::VWMULU);
        is_mixed  = (instr_type_i == vmul_pkg::VMULHSU) || (instr_type_i == vmul_pkg::VWMULSU);
        // {mulh, widened, acc, sub}
        flags_d[3] = (instr_type_i == vmul_pkg::VMULH) || (instr_type_i == vmul_pkg::VMULHU) ||
                     (instr_type_i == vmul_pkg::VMULHSU);
        flags_d[2] = (instr_type_i == vmul_pkg::VWMUL) || (instr_type_i == vmul_pkg::VWMULU) ||
                     (instr_type_i == vmul_pkg::VWMULSU);
        flags_d[1] = (instr_type_i == vmul_pkg::VMACC) || (instr_type_i == vmul_pkg::VNMSAC) ||
                     (instr_type_i == vmul_pkg::VMADD) || (instr_type_i == vmul_pkg::VNMSUB);
        flags_d[0] = (instr_type_i == vmul_pkg::VNMSAC) || (instr_type_i == vmul_pkg::VNMSUB);
    end

    // stage 0 sees these in the same cycle as the operands
    assign src1_signed_o = is_signed ^ is_mixed;
    assign src2_signed_o = is_signed;
    assign swap_addend_o = (instr_type_i == vmul_pkg::VMADD) ||
                           (instr_type_i == vmul_pkg::VNMSUB);

    ////////////////////
    // stage alignment
    ////////////////////

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            valid_q  <= '0;
            sew_s1_o <= vmul_pkg::SEW_8;
            sew_s2_o <= vmul_pkg::SEW_8;
            flags_s1 <= '0;
            flags_s2 <= '0;
        end else begin
            valid_q  <= {valid_q[`VMUL_LATENCY-2:0], valid_i};
            sew_s1_o <= sew_i;
            sew_s2_o <= sew_s1_o;
            // idle slots carry no operation
            flags_s1 <= valid_i ? flags_d : 4'b0;
            flags_s2 <= flags_s1;
        end
    end

    assign {is_mulh_o, is_widened_o, is_acc_o, is_sub_o} = flags_s2;
    assign valid_s2_o = valid_q[`VMUL_LATENCY-2];
    assign valid_o    = valid_q[`VMUL_LATENCY-1];

endmodule

//--- verilog/vmul_operand_prep.sv
`timescale 1ns/1ps
`include "vmul_settings.svh"

module vmul_operand_prep (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  vmul_pkg::sew_t        sew_i,
    input  logic                  src1_signed_i,
    input  logic                  src2_signed_i,
    input  logic                  swap_addend_i,
    input  logic [`VMUL_XLEN-1:0] data_vs1_i,
    input  logic [`VMUL_XLEN-1:0] data_vs2_i,
    input  logic [`VMUL_XLEN-1:0] data_vd_i,
    output logic [`VMUL_XLEN-1:0] mag1_o,
    output logic [`VMUL_XLEN-1:0] mag2_o,
    output logic [`VMUL_XLEN-1:0] addend_o,
    output logic [7:0]            neg_o
);

    vmul_pkg::vword_u src1;
    vmul_pkg::vword_u src2;
    vmul_pkg::vword_u mag1;
    vmul_pkg::vword_u mag2;
    logic [7:0]       neg1;
    logic [7:0]       neg2;

    // per-element absolute value, so the multiplier never sees a sign
    function automatic void to_magnitude(input vmul_pkg::vword_u w, input logic sgn,
                                         input vmul_pkg::sew_t sew,
                                         output vmul_pkg::vword_u mag, output logic [7:0] neg);
        mag = w;
        neg = '0;
        case (sew)
            vmul_pkg::SEW_8: begin
                for (int i = 0; i < 8; i++) begin
                    neg[i] = sgn & w.e8[i][7];
                    mag.e8[i] = neg[i] ? -w.e8[i] : w.e8[i];
                end
            end
            vmul_pkg::SEW_16: begin
                for (int i = 0; i < 4; i++) begin
                    neg[i] = sgn & w.e16[i][15];
                    mag.e16[i] = neg[i] ? -w.e16[i] : w.e16[i];
                end
            end
            vmul_pkg::SEW_32: begin
                for (int i = 0; i < 2; i++) begin
                    neg[i] = sgn & w.e32[i][31];
                    mag.e32[i] = neg[i] ? -w.e32[i] : w.e32[i];
                end
            end
            default: begin
                neg[0] = sgn & w.e64[`VMUL_XLEN-1];
                mag.e64 = neg[0] ? -w.e64 : w.e64;
            end
        endcase
    endfunction

    always_comb begin
        src1.e64 = data_vs1_i;
        // vmadd and vnmsub multiply by the old destination
        src2.e64 = swap_addend_i ? data_vd_i : data_vs2_i;
        to_magnitude(src1, src1_signed_i, sew_i, mag1, neg1);
        to_magnitude(src2, src2_signed_i, sew_i, mag2, neg2);
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            mag1_o   <= '0;
            mag2_o   <= '0;
            addend_o <= '0;
            neg_o    <= '0;
        end else begin
            mag1_o   <= mag1.e64;
            mag2_o   <= mag2.e64;
            addend_o <= swap_addend_i ? data_vs2_i : data_vd_i;
            neg_o    <= neg1 ^ neg2;
        end
    end

endmodule

//--- verilog/vmul_pkg.sv
package vmul_pkg;

`include "vmul_settings.svh"

    ////////////////////
    // instruction codes
    ////////////////////

    typedef enum logic [3:0] {
        VMUL    = 4'd0,
        VMULH   = 4'd1,
        VMULHU  = 4'd2,
        VMULHSU = 4'd3,
        VWMUL   = 4'd4,
        VWMULU  = 4'd5,
        VWMULSU = 4'd6,
        VMACC   = 4'd7,
        VNMSAC  = 4'd8,
        VMADD   = 4'd9,
        VNMSUB  = 4'd10
    } instr_type_t;

    // element width of the operands
    typedef enum logic [1:0] {
        SEW_8  = 2'd0,
        SEW_16 = 2'd1,
        SEW_32 = 2'd2,
        SEW_64 = 2'd3
    } sew_t;

    ////////////////////
    // element views
    ////////////////////

    // one register word, indexed by element for each width
    typedef union packed {
        logic [7:0][7:0]       e8;
        logic [3:0][15:0]      e16;
        logic [1:0][31:0]      e32;
        logic [`VMUL_XLEN-1:0] e64;
    } vword_u;

endpackage

//--- verilog/vmul_product_array.sv
`timescale 1ns/1ps
`include "vmul_settings.svh"

module vmul_product_array (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  vmul_pkg::sew_t        sew_i,
    input  logic [`VMUL_XLEN-1:0] mag1_i,
    input  logic [`VMUL_XLEN-1:0] mag2_i,
    input  logic [7:0]            neg_i,
    input  logic [`VMUL_XLEN-1:0] addend_i,
    output vmul_pkg::vword_u      prod_lo_o,
    output vmul_pkg::vword_u      prod_hi_o,
    output logic [7:0]            neg_o,
    output logic [`VMUL_XLEN-1:0] addend_o
);

    vmul_pkg::vword_u m1;
    vmul_pkg::vword_u m2;
    vmul_pkg::vword_u lo;
    vmul_pkg::vword_u hi;
    logic [15:0]      pp8  [8][8];
    logic [31:0]      pp16 [4][4];
    logic [63:0]      pp32 [2][2];
    logic [127:0]     pp64;

    // [nhi nlo] x [mhi mlo] from its four half-width products
    function automatic logic [127:0] combine(input logic [63:0] ll, input logic [63:0] lh,
                                             input logic [63:0] hl, input logic [63:0] hh,
                                             input int unsigned half);
        combine = {64'b0, ll} + ({64'b0, lh} << half) + ({64'b0, hl} << half) +
                  ({64'b0, hh} << (2 * half));
    endfunction

    ////////////////////
    // partial products
    ////////////////////

    always_comb begin
        m1.e64 = mag1_i;
        m2.e64 = mag2_i;
        for (int i = 0; i < 8; i++) begin
            for (int j = 0; j < 8; j++) begin
                pp8[i][j] = m1.e8[i] * m2.e8[j];
            end
        end
        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 4; j++) begin
                pp16[i][j] = 32'(combine(64'(pp8[2*i][2*j]), 64'(pp8[2*i][2*j+1]),
                                         64'(pp8[2*i+1][2*j]), 64'(pp8[2*i+1][2*j+1]), 8));
            end
        end
        for (int i = 0; i < 2; i++) begin
            for (int j = 0; j < 2; j++) begin
                pp32[i][j] = 64'(combine(64'(pp16[2*i][2*j]), 64'(pp16[2*i][2*j+1]),
                                         64'(pp16[2*i+1][2*j]), 64'(pp16[2*i+1][2*j+1]), 16));
            end
        end
        pp64 = combine(pp32[0][0], pp32[0][1], pp32[1][0], pp32[1][1], 32);
    end

    // only the diagonal products belong to an element
    always_comb begin
        lo = '0;
        hi = '0;
        case (sew_i)
            vmul_pkg::SEW_8: begin
                for (int k = 0; k < 8; k++) begin
                    {hi.e8[k], lo.e8[k]} = pp8[k][k];
                end
            end
            vmul_pkg::SEW_16: begin
                for (int k = 0; k < 4; k++) begin
                    {hi.e16[k], lo.e16[k]} = pp16[k][k];
                end
            end
            vmul_pkg::SEW_32: begin
                for (int k = 0; k < 2; k++) begin
                    {hi.e32[k], lo.e32[k]} = pp32[k][k];
                end
            end
            default: begin
                {hi.e64, lo.e64} = pp64;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            prod_lo_o <= '0;
            prod_hi_o <= '0;
            neg_o     <= '0;
            addend_o  <= '0;
        end else begin
            prod_lo_o <= lo;
            prod_hi_o <= hi;
            neg_o     <= neg_i;
            addend_o  <= addend_i;
        end
    end

endmodule

//--- verilog/vmul_result_fmt.sv
`timescale 1ns/1ps
`include "vmul_settings.svh"

module vmul_result_fmt (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  logic                  valid_i,
    input  vmul_pkg::sew_t        sew_i,
    input  logic                  is_mulh_i,
    input  logic                  is_widened_i,
    input  logic                  is_acc_i,
    input  logic                  is_sub_i,
    input  vmul_pkg::vword_u      prod_lo_i,
    input  vmul_pkg::vword_u      prod_hi_i,
    input  logic [7:0]            neg_i,
    input  logic [`VMUL_XLEN-1:0] addend_i,
    output logic [`VMUL_XLEN-1:0] data_vd_o
);

    vmul_pkg::vword_u add;
    vmul_pkg::vword_u res;

    // one element, sign restored; the caller keeps the bits it needs
    function automatic logic [127:0] elem_result(input logic [127:0] mag, input logic neg,
                                                 input logic [63:0] addend,
                                                 input int unsigned ew);
        logic [127:0] full;
        full = neg ? -mag : mag;
        if (is_acc_i) begin
            // only the low half reaches the accumulator
            return is_sub_i ? {64'b0, addend} - full : {64'b0, addend} + full;
        end
        if (is_mulh_i) begin
            return full >> ew;
        end
        return full;
    endfunction

    always_comb begin
        add.e64 = addend_i;
        res = '0;
        case (sew_i)
            vmul_pkg::SEW_8: begin
                for (int k = 0; k < 8; k++) begin
                    if (!is_widened_i) begin
                        res.e8[k] = 8'(elem_result(128'({prod_hi_i.e8[k], prod_lo_i.e8[k]}),
                                                   neg_i[k], 64'(add.e8[k]), 8));
                    end else if (k < 4) begin
                        res.e16[k] = 16'(elem_result(128'({prod_hi_i.e8[k], prod_lo_i.e8[k]}),
                                                     neg_i[k], 64'(add.e8[k]), 8));
                    end
                end
            end
            vmul_pkg::SEW_16: begin
                for (int k = 0; k < 4; k++) begin
                    if (!is_widened_i) begin
                        res.e16[k] = 16'(elem_result(128'({prod_hi_i.e16[k], prod_lo_i.e16[k]}),
                                                     neg_i[k], 64'(add.e16[k]), 16));
                    end else if (k < 2) begin
                        res.e32[k] = 32'(elem_result(128'({prod_hi_i.e16[k], prod_lo_i.e16[k]}),
                                                     neg_i[k], 64'(add.e16[k]), 16));
                    end
                end
            end
            vmul_pkg::SEW_32: begin
                for (int k = 0; k < 2; k++) begin
                    if (!is_widened_i) begin
                        res.e32[k] = 32'(elem_result(128'({prod_hi_i.e32[k], prod_lo_i.e32[k]}),
                                                     neg_i[k], 64'(add.e32[k]), 32));
                    end else if (k < 1) begin
                        res.e64 = 64'(elem_result(128'({prod_hi_i.e32[k], prod_lo_i.e32[k]}),
                                                  neg_i[k], 64'(add.e32[k]), 32));
                    end
                end
            end
            default: begin
                // no 128-bit destination, widening stays zero
                if (!is_widened_i) begin
                    res.e64 = 64'(elem_result({prod_hi_i.e64, prod_lo_i.e64}, neg_i[0],
                                              add.e64, 64));
                end
            end
        endcase
    end

    // output holds between results
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            data_vd_o <= '0;
        end else if (valid_i) begin
            data_vd_o <= res.e64;
        end
    end

endmodule

//--- verilog/vmul_settings.svh
`ifndef VMUL_SETTINGS_SVH
`define VMUL_SETTINGS_SVH

////////////////////
// shared constants
////////////////////

// width of one vector register slice
`define VMUL_XLEN 64

// rising edges from the sampled valid_i to valid_o
`define VMUL_LATENCY 3

`endif

//--- verilog/vmul_top.sv
`timescale 1ns/1ps
`include "vmul_settings.svh"

module vmul_top (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  logic                  valid_i,
    input  vmul_pkg::instr_type_t instr_type_i,
    input  vmul_pkg::sew_t        sew_i,
    input  logic [`VMUL_XLEN-1:0] data_vs1_i,
    input  logic [`VMUL_XLEN-1:0] data_vs2_i,
    input  logic [`VMUL_XLEN-1:0] data_vd_i,
    output logic                  valid_o,
    output logic [`VMUL_XLEN-1:0] data_vd_o
);

    ////////////////////
    // control to stages
    ////////////////////

    logic           src1_signed;
    logic           src2_signed;
    logic           swap_addend;
    vmul_pkg::sew_t sew_s1;
    vmul_pkg::sew_t sew_s2;
    logic           is_mulh;
    logic           is_widened;
    logic           is_acc;
    logic           is_sub;
    logic           valid_s2;

    ////////////////////
    // datapath
    ////////////////////

    logic [`VMUL_XLEN-1:0] mag1;
    logic [`VMUL_XLEN-1:0] mag2;
    logic [`VMUL_XLEN-1:0] addend_s1;
    logic [`VMUL_XLEN-1:0] addend_s2;
    logic [7:0]            neg_s1;
    logic [7:0]            neg_s2;
    vmul_pkg::vword_u      prod_lo;
    vmul_pkg::vword_u      prod_hi;

    vmul_ctrl u_ctrl (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .valid_i       (valid_i),
        .instr_type_i  (instr_type_i),
        .sew_i         (sew_i),
        .src1_signed_o (src1_signed),
        .src2_signed_o (src2_signed),
        .swap_addend_o (swap_addend),
        .sew_s1_o      (sew_s1),
        .sew_s2_o      (sew_s2),
        .is_mulh_o     (is_mulh),
        .is_widened_o  (is_widened),
        .is_acc_o      (is_acc),
        .is_sub_o      (is_sub),
        .valid_s2_o    (valid_s2),
        .valid_o       (valid_o)
    );

    vmul_operand_prep u_operand_prep (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .sew_i         (sew_i),
        .src1_signed_i (src1_signed),
        .src2_signed_i (src2_signed),
        .swap_addend_i (swap_addend),
        .data_vs1_i    (data_vs1_i),
        .data_vs2_i    (data_vs2_i),
        .data_vd_i     (data_vd_i),
        .mag1_o        (mag1),
        .mag2_o        (mag2),
        .addend_o      (addend_s1),
        .neg_o         (neg_s1)
    );

    vmul_product_array u_product_array (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .sew_i     (sew_s1),
        .mag1_i    (mag1),
        .mag2_i    (mag2),
        .neg_i     (neg_s1),
        .addend_i  (addend_s1),
        .prod_lo_o (prod_lo),
        .prod_hi_o (prod_hi),
        .neg_o     (neg_s2),
        .addend_o  (addend_s2)
    );

    vmul_result_fmt u_result_fmt (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .valid_i      (valid_s2),
        .sew_i        (sew_s2),
        .is_mulh_i    (is_mulh),
        .is_widened_i (is_widened),
        .is_acc_i     (is_acc),
        .is_sub_i     (is_sub),
        .prod_lo_i    (prod_lo),
        .prod_hi_i    (prod_hi),
        .neg_i        (neg_s2),
        .addend_i     (addend_s2),
        .data_vd_o    (data_vd_o)
    );

endmodule
